//--- all.f
+incdir+.
tcdm_pkg.sv
tcdm_rr_arbiter.sv
tcdm_tile_xbar.sv
tcdm_group_interco.sv
tb_group_interco.sv

//--- run.sh
#!/bin/sh
# Build and run the group interconnect testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module tb_group_interco \
  -f all.f

# The simulation may stop early, the search below decides
out=$(./obj_dir/Vtb_group_interco 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
  exit 0
else
  exit 1
fi

//--- tb_group_interco.sv
/* Testbench for the TCDM group interconnect. Applies a stimulus table on the
   master request ports, models the banks and checks both return paths. */

`include "tcdm_macros.svh"

module tb_group_interco
  import tcdm_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NumTiles   = `TCDM_NUM_TILES;
  localparam int unsigned NumPorts   = `TCDM_NUM_PORTS;
  localparam int unsigned NumLinks   = NumTiles * NumPorts;
  localparam int unsigned NumStim    = 26;
  localparam int unsigned WdogCycles = NumStim * 40 + 100;
  localparam int unsigned BurstLat   = 0;  // Single request into an idle DUT
  localparam int unsigned BurstCont  = 2;  // All tiles hit one target on port 0
  localparam int unsigned BurstBp    = 3;  // Random ready on both sides
  localparam int unsigned ContTile   = 2;
  localparam int unsigned ContDepth  = 2;  // Requests per tile in the contention burst

  typedef struct packed {
    int unsigned burst;
    tile_id_t    src;
    int unsigned port;
    grp_addr_t   addr;
    logic        wen;
    be_t         be;
    data_t       data;
    meta_id_t    meta;
    core_id_t    core;
    amo_t        amo;
  } stim_t;

  // burst, src, port, addr (row|bank|tile), wen, be, data, meta, core, amo
  stim_t stim_table [NumStim] = '{
    '{0, 2'd1, 1, 14'h0427, 1'b1, 4'hf, 32'h1111_0001, 4'h1, 2'd0, 4'h0},
    '{1, 2'd0, 0, 14'h0105, 1'b1, 4'h3, 32'h2222_0001, 4'h2, 2'd1, 4'h0},
    '{1, 2'd1, 1, 14'h3ff8, 1'b0, 4'h0, 32'h2222_0002, 4'h3, 2'd2, 4'h0},
    '{1, 2'd2, 0, 14'h0012, 1'b1, 4'hc, 32'h2222_0003, 4'h4, 2'd3, 4'h5},
    '{1, 2'd3, 1, 14'h2aa9, 1'b1, 4'h1, 32'h2222_0004, 4'h5, 2'd0, 4'ha},
    '{1, 2'd3, 0, 14'h1557, 1'b0, 4'hf, 32'h2222_0005, 4'h6, 2'd1, 4'h0},
    '{1, 2'd0, 1, 14'h0ffe, 1'b1, 4'h8, 32'h2222_0006, 4'h7, 2'd2, 4'h3},
    '{2, 2'd0, 0, 14'h0102, 1'b1, 4'hf, 32'h3333_0001, 4'h8, 2'd0, 4'h0},
    '{2, 2'd1, 0, 14'h0206, 1'b1, 4'hf, 32'h3333_0002, 4'h9, 2'd1, 4'h0},
    '{2, 2'd2, 0, 14'h030a, 1'b0, 4'hf, 32'h3333_0003, 4'ha, 2'd2, 4'h0},
    '{2, 2'd3, 0, 14'h040e, 1'b1, 4'h6, 32'h3333_0004, 4'hb, 2'd3, 4'h2},
    '{2, 2'd0, 0, 14'h0502, 1'b0, 4'hf, 32'h3333_0005, 4'hc, 2'd0, 4'h0},
    '{2, 2'd1, 0, 14'h0606, 1'b1, 4'h1, 32'h3333_0006, 4'hd, 2'd1, 4'h0},
    '{2, 2'd2, 0, 14'h070a, 1'b1, 4'hf, 32'h3333_0007, 4'he, 2'd2, 4'h6},
    '{2, 2'd3, 0, 14'h080e, 1'b1, 4'h2, 32'h3333_0008, 4'hf, 2'd3, 4'h0},
    '{3, 2'd0, 0, 14'h0a11, 1'b1, 4'hf, 32'h4444_0001, 4'h0, 2'd0, 4'h0},
    '{3, 2'd0, 0, 14'h0a15, 1'b1, 4'h1, 32'h4444_0002, 4'h1, 2'd0, 4'h0},
    '{3, 2'd1, 1, 14'h0b22, 1'b0, 4'h0, 32'h4444_0003, 4'h2, 2'd1, 4'h7},
    '{3, 2'd1, 1, 14'h0b26, 1'b1, 4'h2, 32'h4444_0004, 4'h3, 2'd1, 4'h0},
    '{3, 2'd2, 0, 14'h1c40, 1'b1, 4'h4, 32'h4444_0005, 4'h4, 2'd2, 4'h0},
    '{3, 2'd3, 1, 14'h2e63, 1'b0, 4'hf, 32'h4444_0006, 4'h5, 2'd3, 4'h9},
    '{3, 2'd2, 1, 14'h0f71, 1'b1, 4'h8, 32'h4444_0007, 4'h6, 2'd2, 4'h0},
    '{3, 2'd1, 0, 14'h1b21, 1'b1, 4'hf, 32'h4444_0008, 4'h7, 2'd1, 4'h1},
    '{3, 2'd3, 0, 14'h2c31, 1'b1, 4'h3, 32'h4444_0009, 4'h8, 2'd0, 4'h0},
    '{3, 2'd0, 1, 14'h1c44, 1'b0, 4'h0, 32'h4444_000a, 4'h9, 2'd3, 4'h0},
    '{3, 2'd2, 0, 14'h3d50, 1'b1, 4'hc, 32'h4444_000b, 4'ha, 2'd2, 4'h4}
  };

  logic clk_i    = 1'b0;
  logic rnd_mode = 1'b0;
  logic rst_n_i;

  tcdm_master_req_t  [NumTiles-1:0][NumPorts-1:0] mst_req_i;
  logic              [NumTiles-1:0][NumPorts-1:0] mst_req_valid_i;
  logic              [NumTiles-1:0][NumPorts-1:0] mst_req_ready_o;
  tcdm_master_resp_t [NumTiles-1:0][NumPorts-1:0] mst_resp_o;
  logic              [NumTiles-1:0][NumPorts-1:0] mst_resp_valid_o;
  logic              [NumTiles-1:0][NumPorts-1:0] mst_resp_ready_i;
  tcdm_slave_req_t   [NumTiles-1:0][NumPorts-1:0] slv_req_o;
  logic              [NumTiles-1:0][NumPorts-1:0] slv_req_valid_o;
  logic              [NumTiles-1:0][NumPorts-1:0] slv_req_ready_i;
  tcdm_slave_resp_t  [NumTiles-1:0][NumPorts-1:0] slv_resp_i;
  logic              [NumTiles-1:0][NumPorts-1:0] slv_resp_valid_i;
  logic              [NumTiles-1:0][NumPorts-1:0] slv_resp_ready_o;

  int unsigned       send_q     [NumTiles][NumPorts][$];  // Table rows per master port
  tcdm_slave_req_t   exp_req_q  [NumTiles][NumPorts][$];
  tcdm_master_resp_t exp_resp_q [NumTiles][NumPorts][$];
  tcdm_slave_resp_t  mem_q      [NumTiles][NumPorts][$];  // Bank answers still to send
  tile_id_t          arr_q      [NumTiles][NumPorts][$];  // Initiators in arrival order
  int                pending    = 0;
  int                mism_errs  = 0;
  int                other_errs = 0;

  always #2 clk_i = ~clk_i;

  tcdm_group_interco i_tcdm_group_interco (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .mst_req_i       (mst_req_i       ),
    .mst_req_valid_i (mst_req_valid_i ),
    .mst_req_ready_o (mst_req_ready_o ),
    .mst_resp_o      (mst_resp_o      ),
    .mst_resp_valid_o(mst_resp_valid_o),
    .mst_resp_ready_i(mst_resp_ready_i),
    .slv_req_o       (slv_req_o       ),
    .slv_req_valid_o (slv_req_valid_o ),
    .slv_req_ready_i (slv_req_ready_i ),
    .slv_resp_i      (slv_resp_i      ),
    .slv_resp_valid_i(slv_resp_valid_i),
    .slv_resp_ready_o(slv_resp_ready_o)
  );

  task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mism_errs++;
      $display("mismatch %s got %h exp %h", name, got, exp);
    end
  endtask

  // Output must be valid one cycle after the input transfer
  task automatic check_min_latency(input int unsigned k);
    tile_id_t    src;
    tile_id_t    tgt;
    int unsigned port;
    src  = stim_table[k].src;
    tgt  = tile_id_t'(stim_table[k].addr);
    port = stim_table[k].port;
    do @(negedge clk_i); while (!(mst_req_valid_i[src][port] && mst_req_ready_o[src][port]));
    @(negedge clk_i);
    compare_val($sformatf("slv_req_valid_o[%0d][%0d]", tgt, port),
                32'(slv_req_valid_o[tgt][port]), 32'h1);
  endtask

  // Ready on both sides, random only in the back-pressure burst
  initial begin
    slv_req_ready_i  = '1;
    mst_resp_ready_i = '1;
    forever begin
      @(posedge clk_i);
      #0.5;
      slv_req_ready_i  = rnd_mode ? NumLinks'($urandom) : '1;
      mst_resp_ready_i = rnd_mode ? NumLinks'($urandom) : '1;
    end
  end

  for (genvar i = 0; i < NumTiles; i++) begin : gen_tile
    for (genvar j = 0; j < NumPorts; j++) begin : gen_port

      // Master request driver, expectations are booked at the handshake
      initial begin
        stim_t    s;
        tile_id_t tgt;
        mst_req_i[i][j]       = '0;
        mst_req_valid_i[i][j] = 1'b0;
        forever begin
          @(posedge clk_i);
          #0.5;
          if (send_q[i][j].size() == 0) begin
            mst_req_valid_i[i][j] = 1'b0;
          end else begin
            s   = stim_table[send_q[i][j].pop_front()];
            tgt = tile_id_t'(s.addr);              // Low address bits pick the tile
            mst_req_i[i][j] = tcdm_master_req_t'{meta_id: s.meta, core_id: s.core,
              amo: s.amo, data: s.data, wen: s.wen, be: s.be, tgt_addr: s.addr};
            mst_req_valid_i[i][j] = 1'b1;
            do @(negedge clk_i); while (!mst_req_ready_o[i][j]);
            exp_req_q[tgt][j].push_back(tcdm_slave_req_t'{meta_id: s.meta, core_id: s.core,
              amo: s.amo, data: s.data, wen: s.wen, be: s.be,
              tgt_addr: bank_addr_t'(s.addr >> `TCDM_TILE_W), ini_addr: tile_id_t'(i)});
            exp_resp_q[i][j].push_back(tcdm_master_resp_t'{meta_id: s.meta,
              core_id: s.core, amo: s.amo, data: ~s.data});
          end
        end
      end

      // Bank model, answers in arrival order
      initial begin
        slv_resp_i[i][j]       = '0;
        slv_resp_valid_i[i][j] = 1'b0;
        forever begin
          @(posedge clk_i);
          #0.5;
          if (mem_q[i][j].size() == 0) begin
            slv_resp_valid_i[i][j] = 1'b0;
          end else begin
            slv_resp_i[i][j]       = mem_q[i][j].pop_front();
            slv_resp_valid_i[i][j] = 1'b1;
            do @(negedge clk_i); while (!slv_resp_ready_o[i][j]);
          end
        end
      end

      // Slave request checker, in order per initiator
      initial begin
        tcdm_slave_req_t got;
        tcdm_slave_req_t exp;
        int              found;
        string           pfx;
        forever begin
          @(negedge clk_i);
          if (slv_req_valid_o[i][j] && slv_req_ready_i[i][j]) begin
            got   = slv_req_o[i][j];
            found = -1;
            pfx   = $sformatf("slv_req_o[%0d][%0d]", i, j);
            for (int k = 0; k < exp_req_q[i][j].size(); k++) begin
              if (found < 0 && exp_req_q[i][j][k].ini_addr == got.ini_addr) begin
                found = k;
              end
            end
            if (found < 0) begin
              other_errs++;
              $display("unexpected request on slave tile %0d port %0d from tile %0d",
                       i, j, got.ini_addr);
            end else begin
              exp = exp_req_q[i][j][found];
              exp_req_q[i][j].delete(found);
              compare_val({pfx, ".tgt_addr"}, 32'(got.tgt_addr), 32'(exp.tgt_addr));
              compare_val({pfx, ".wen"}, 32'(got.wen), 32'(exp.wen));
              compare_val({pfx, ".be"}, 32'(got.be), 32'(exp.be));
              compare_val({pfx, ".data"}, got.data, exp.data);
              compare_val({pfx, ".amo"}, 32'(got.amo), 32'(exp.amo));
              compare_val({pfx, ".meta_id"}, 32'(got.meta_id), 32'(exp.meta_id));
              compare_val({pfx, ".core_id"}, 32'(got.core_id), 32'(exp.core_id));
            end
            arr_q[i][j].push_back(got.ini_addr);
            mem_q[i][j].push_back(tcdm_slave_resp_t'{meta_id: got.meta_id,
              core_id: got.core_id, amo: got.amo, data: ~got.data, ini_addr: got.ini_addr});
          end
        end
      end

      // Master response checker, keyed on the unique data word
      initial begin
        tcdm_master_resp_t got;
        int                found;
        string             pfx;
        forever begin
          @(negedge clk_i);
          if (mst_resp_valid_o[i][j] && mst_resp_ready_i[i][j]) begin
            got   = mst_resp_o[i][j];
            found = -1;
            pfx   = $sformatf("mst_resp_o[%0d][%0d]", i, j);
            for (int k = 0; k < exp_resp_q[i][j].size(); k++) begin
              if (found < 0 && exp_resp_q[i][j][k].data == got.data) begin
                found = k;
              end
            end
            if (found < 0) begin
              other_errs++;
              $display("unexpected response on master tile %0d port %0d, data %h",
                       i, j, got.data);
            end else begin
              compare_val({pfx, ".meta_id"}, 32'(got.meta_id),
                          32'(exp_resp_q[i][j][found].meta_id));
              compare_val({pfx, ".core_id"}, 32'(got.core_id),
                          32'(exp_resp_q[i][j][found].core_id));
              compare_val({pfx, ".amo"}, 32'(got.amo), 32'(exp_resp_q[i][j][found].amo));
              exp_resp_q[i][j].delete(found);
              pending--;
            end
          end
        end
      end

    end : gen_port
  end : gen_tile

  initial begin
    repeat (WdogCycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles with %0d transfers open", WdogCycles, pending);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h5bf1_32d4));
    rst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #0.5;
    rst_n_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      compare_val("slv_req_valid_o", 32'(slv_req_valid_o), 32'h0);
      compare_val("mst_resp_valid_o", 32'(mst_resp_valid_o), 32'h0);
    end
    for (int unsigned b = 0; b <= BurstBp; b++) begin
      rnd_mode = (b == BurstBp);
      arr_q[ContTile][0].delete();
      for (int unsigned k = 0; k < NumStim; k++) begin
        if (stim_table[k].burst == b) begin
          send_q[stim_table[k].src][stim_table[k].port].push_back(k);
          pending++;
        end
      end
      if (b == BurstLat) begin
        check_min_latency(0);
      end
      while (pending != 0) @(negedge clk_i);
      if (b == BurstCont) begin
        if (arr_q[ContTile][0].size() != ContDepth * NumTiles) begin
          other_errs++;
          $display("contention burst delivered %0d of %0d requests",
                   arr_q[ContTile][0].size(), ContDepth * NumTiles);
        end
        // Every tile re-requests at once, so any window of NumTiles grants is distinct
        for (int a = 0; a < arr_q[ContTile][0].size(); a++) begin
          for (int c = a + 1; c < arr_q[ContTile][0].size() && c < a + int'(NumTiles); c++) begin
            if (arr_q[ContTile][0][a] == arr_q[ContTile][0][c]) begin
              other_errs++;
              $display("round robin served tile %0d twice within %0d grants",
                       arr_q[ContTile][0][a], NumTiles);
            end
          end
        end
      end
    end
    repeat (5) @(negedge clk_i);
    for (int t = 0; t < NumTiles; t++) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (exp_req_q[t][p].size() != 0 || exp_resp_q[t][p].size() != 0) begin
          other_errs++;
          $display("tile %0d port %0d still waits for %0d requests and %0d responses",
                   t, p, exp_req_q[t][p].size(), exp_resp_q[t][p].size());
        end
      end
    end
    $display("run done, %0d mismatches, %0d other errors", mism_errs, other_errs);
    if (mism_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tcdm_group_interco.sv
/* Intra-group TCDM remote-port interconnect. Packs master requests into
   flits, routes them per port to the target tile and unpacks them for the
   banks; responses go back the same way to the initiating tile. */

`include "tcdm_macros.svh"

module tcdm_group_interco
  import tcdm_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  // Master side, requests leave the tiles here
  input  tcdm_master_req_t  [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] mst_req_i,
  input  logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] mst_req_valid_i,
  output logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] mst_req_ready_o,
  output tcdm_master_resp_t [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] mst_resp_o,
  output logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] mst_resp_valid_o,
  input  logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] mst_resp_ready_i,
  // Slave side, towards the banks of the target tile
  output tcdm_slave_req_t   [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] slv_req_o,
  output logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] slv_req_valid_o,
  input  logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] slv_req_ready_i,
  input  tcdm_slave_resp_t  [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] slv_resp_i,
  input  logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] slv_resp_valid_i,
  output logic              [`TCDM_NUM_TILES-1:0][`TCDM_NUM_PORTS-1:0] slv_resp_ready_o
);

  localparam int unsigned NumTiles = `TCDM_NUM_TILES;
  localparam int unsigned NumPorts = `TCDM_NUM_PORTS;
  localparam int unsigned TileW    = `TCDM_TILE_W;
  localparam int unsigned AddrW    = $bits(grp_addr_t);

  // Crossbar side signals are port-major
  flit_req_t  [NumPorts-1:0][NumTiles-1:0] req_in_flit;
  tile_id_t   [NumPorts-1:0][NumTiles-1:0] req_sel;
  logic       [NumPorts-1:0][NumTiles-1:0] req_in_valid;
  logic       [NumPorts-1:0][NumTiles-1:0] req_in_ready;
  flit_req_t  [NumPorts-1:0][NumTiles-1:0] req_out_flit;
  logic       [NumPorts-1:0][NumTiles-1:0] req_out_valid;
  logic       [NumPorts-1:0][NumTiles-1:0] req_out_ready;

  flit_resp_t [NumPorts-1:0][NumTiles-1:0] resp_in_flit;
  tile_id_t   [NumPorts-1:0][NumTiles-1:0] resp_sel;
  logic       [NumPorts-1:0][NumTiles-1:0] resp_in_valid;
  logic       [NumPorts-1:0][NumTiles-1:0] resp_in_ready;
  flit_resp_t [NumPorts-1:0][NumTiles-1:0] resp_out_flit;
  logic       [NumPorts-1:0][NumTiles-1:0] resp_out_valid;
  logic       [NumPorts-1:0][NumTiles-1:0] resp_out_ready;

  for (genvar i = 0; i < NumTiles; i++) begin : gen_tile
    for (genvar j = 0; j < NumPorts; j++) begin : gen_port

      // Master request into request flit
      assign req_in_flit[j][i] = flit_req_t'{
        hdr: flit_req_hdr_t'{
          meta_id    : mst_req_i[i][j].meta_id,
          core_id    : mst_req_i[i][j].core_id,
          src_tile_id: tile_id_t'(i),            // Return address for the response
          tgt_addr   : mst_req_i[i][j].tgt_addr
        },
        payload: flit_req_payload_t'{
          amo : mst_req_i[i][j].amo,
          wen : mst_req_i[i][j].wen,
          be  : mst_req_i[i][j].be,
          data: mst_req_i[i][j].data
        }
      };
      assign req_sel[j][i]         = req_in_flit[j][i].hdr.tgt_addr[TileW-1:0]; // Low tile bits
      assign req_in_valid[j][i]    = mst_req_valid_i[i][j];
      assign mst_req_ready_o[i][j] = req_in_ready[j][i];

      // Request flit into slave request, tile bits stripped
      assign slv_req_o[i][j] = tcdm_slave_req_t'{
        meta_id : req_out_flit[j][i].hdr.meta_id,
        core_id : req_out_flit[j][i].hdr.core_id,
        amo     : req_out_flit[j][i].payload.amo,
        data    : req_out_flit[j][i].payload.data,
        wen     : req_out_flit[j][i].payload.wen,
        be      : req_out_flit[j][i].payload.be,
        tgt_addr: req_out_flit[j][i].hdr.tgt_addr[AddrW-1:TileW],
        ini_addr: req_out_flit[j][i].hdr.src_tile_id
      };
      assign slv_req_valid_o[i][j] = req_out_valid[j][i];
      assign req_out_ready[j][i]   = slv_req_ready_i[i][j];

      // Slave response into response flit
      assign resp_in_flit[j][i] = flit_resp_t'{
        hdr: flit_resp_hdr_t'{
          meta_id: slv_resp_i[i][j].meta_id,
          core_id: slv_resp_i[i][j].core_id,
          tile_id: slv_resp_i[i][j].ini_addr
        },
        payload: flit_resp_payload_t'{
          amo : slv_resp_i[i][j].amo,
          data: slv_resp_i[i][j].data
        }
      };
      assign resp_sel[j][i]         = resp_in_flit[j][i].hdr.tile_id;
      assign resp_in_valid[j][i]    = slv_resp_valid_i[i][j];
      assign slv_resp_ready_o[i][j] = resp_in_ready[j][i];

      // Response flit back into master response
      assign mst_resp_o[i][j] = tcdm_master_resp_t'{
        meta_id: resp_out_flit[j][i].hdr.meta_id,
        core_id: resp_out_flit[j][i].hdr.core_id,
        amo    : resp_out_flit[j][i].payload.amo,
        data   : resp_out_flit[j][i].payload.data
      };
      assign mst_resp_valid_o[i][j] = resp_out_valid[j][i];
      assign resp_out_ready[j][i]   = mst_resp_ready_i[i][j];

    end : gen_port
  end : gen_tile

  // One request and one response crossbar per remote port
  for (genvar j = 0; j < NumPorts; j++) begin : gen_xbar

    tcdm_tile_xbar #(
      .payload_t(flit_req_t      ),
      .NumTiles (NumTiles        )
    ) i_req_xbar (
      .clk_i    (clk_i           ),
      .rst_n_i  (rst_n_i         ),
      .data_i   (req_in_flit[j]  ),
      .valid_i  (req_in_valid[j] ),
      .ready_o  (req_in_ready[j] ),
      .sel_i    (req_sel[j]      ),
      .data_o   (req_out_flit[j] ),
      .valid_o  (req_out_valid[j]),
      .ready_i  (req_out_ready[j])
    );

    tcdm_tile_xbar #(
      .payload_t(flit_resp_t      ),
      .NumTiles (NumTiles         )
    ) i_resp_xbar (
      .clk_i    (clk_i            ),
      .rst_n_i  (rst_n_i          ),
      .data_i   (resp_in_flit[j]  ),
      .valid_i  (resp_in_valid[j] ),
      .ready_o  (resp_in_ready[j] ),
      .sel_i    (resp_sel[j]      ),
      .data_o   (resp_out_flit[j] ),
      .valid_o  (resp_out_valid[j]),
      .ready_i  (resp_out_ready[j])
    );

  end : gen_xbar

endmodule

//--- tcdm_macros.svh
/* Sizes of the TCDM group interconnect. Include in every RTL file
   that needs a width or a count; the package builds its types on these. */

`ifndef TCDM_MACROS_SVH
`define TCDM_MACROS_SVH

// Group topology
`define TCDM_NUM_TILES 4
`define TCDM_NUM_PORTS 2   // Remote ports per tile, counted from 0

// Address split inside the group, row | bank | tile
`define TCDM_TILE_W 2
`define TCDM_BANK_W 4
`define TCDM_ROW_W  8

// Payload fields
`define TCDM_DATA_W 32
`define TCDM_BE_W   4
`define TCDM_AMO_W  4

// Tags returned with a response
`define TCDM_META_W 4      // Register file tag
`define TCDM_CORE_W 2      // Issuing core inside the tile

`endif

//--- tcdm_pkg.sv
/* Request, response and flit types of the TCDM group interconnect.
   Import with a wildcard in the module header. */

`include "tcdm_macros.svh"

package tcdm_pkg;

  typedef logic [`TCDM_TILE_W-1:0]                          tile_id_t;
  typedef logic [`TCDM_ROW_W+`TCDM_BANK_W+`TCDM_TILE_W-1:0] grp_addr_t;  // row | bank | tile
  typedef logic [`TCDM_ROW_W+`TCDM_BANK_W-1:0]              bank_addr_t; // row | bank

  typedef logic [`TCDM_META_W-1:0] meta_id_t;
  typedef logic [`TCDM_CORE_W-1:0] core_id_t;
  typedef logic [`TCDM_AMO_W-1:0]  amo_t;
  typedef logic [`TCDM_DATA_W-1:0] data_t;
  typedef logic [`TCDM_BE_W-1:0]   be_t;

  // Tile side, the address still holds the target tile
  typedef struct packed {
    meta_id_t  meta_id;
    core_id_t  core_id;
    amo_t      amo;
    data_t     data;
    logic      wen;
    be_t       be;
    grp_addr_t tgt_addr;
  } tcdm_master_req_t;

  typedef struct packed {
    meta_id_t   meta_id;
    core_id_t   core_id;
    amo_t       amo;
    data_t      data;
    logic       wen;
    be_t        be;
    bank_addr_t tgt_addr;
    tile_id_t   ini_addr;  // Initiating tile
  } tcdm_slave_req_t;

  typedef struct packed {
    meta_id_t meta_id;
    core_id_t core_id;
    amo_t     amo;
    data_t    data;
    tile_id_t ini_addr;    // Copied from the request
  } tcdm_slave_resp_t;

  typedef struct packed {
    meta_id_t meta_id;
    core_id_t core_id;
    amo_t     amo;
    data_t    data;
  } tcdm_master_resp_t;

  typedef struct packed {
    meta_id_t  meta_id;
    core_id_t  core_id;
    tile_id_t  src_tile_id;
    grp_addr_t tgt_addr;
  } flit_req_hdr_t;

  typedef struct packed {
    amo_t  amo;
    logic  wen;
    be_t   be;
    data_t data;
  } flit_req_payload_t;

  typedef struct packed {
    flit_req_hdr_t     hdr;
    flit_req_payload_t payload;
  } flit_req_t;

  typedef struct packed {
    meta_id_t meta_id;
    core_id_t core_id;
    tile_id_t tile_id;     // Destination of the response
  } flit_resp_hdr_t;

  typedef struct packed {
    amo_t  amo;
    data_t data;
  } flit_resp_payload_t;

  typedef struct packed {
    flit_resp_hdr_t     hdr;
    flit_resp_payload_t payload;
  } flit_resp_t;

endpackage

//--- tcdm_rr_arbiter.sv
/* Round-robin arbiter for one crossbar output. Grants the first requester
   at or after the priority pointer; the pointer moves on a taken grant. */

`include "tcdm_macros.svh"

module tcdm_rr_arbiter #(
  parameter  int unsigned NumReq = `TCDM_NUM_TILES,
  localparam int unsigned IdxW   = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [NumReq-1:0] req_i,
  input  logic              gnt_en_i,   // Output can take a flit
  output logic [NumReq-1:0] gnt_o,
  output logic [IdxW-1:0]   gnt_idx_o
);

  logic [IdxW-1:0]   ptr_q;
  logic [NumReq-1:0] winner;
  logic [IdxW-1:0]   winner_idx;
  logic              any_req;

  // Search starts at the pointer and wraps around
  always_comb begin
    int unsigned idx;
    winner     = '0;
    winner_idx = '0;
    any_req    = 1'b0;
    for (int unsigned k = 0; k < NumReq; k++) begin
      idx = (ptr_q + k) % NumReq;
      if (!any_req && req_i[idx]) begin
        any_req         = 1'b1;
        winner[idx]     = 1'b1;
        winner_idx      = IdxW'(idx);
      end
    end
  end

  assign gnt_o     = gnt_en_i ? winner : '0;
  assign gnt_idx_o = winner_idx;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (gnt_en_i && any_req) begin
      // Winner drops to lowest priority
      if (winner_idx == IdxW'(NumReq - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= winner_idx + 1'b1;
      end
    end
  end

  a_gnt_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o)
  ) else $error("arbiter grant is not one-hot");

  a_gnt_to_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (gnt_o & ~req_i) == '0
  ) else $error("arbiter granted an idle input");

endmodule

//--- tcdm_tile_xbar.sv
/* Tile-to-tile valid/ready crossbar. Every input names its output through
   sel_i; each output arbitrates round-robin and holds one flit in a register.
   The payload type is a parameter so request and response flits share it. */

`include "tcdm_macros.svh"

module tcdm_tile_xbar
  import tcdm_pkg::*;
#(
  parameter type         payload_t = logic,
  parameter int unsigned NumTiles  = `TCDM_NUM_TILES
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Inputs, one per source tile
  input  payload_t [NumTiles-1:0] data_i,
  input  logic     [NumTiles-1:0] valid_i,
  output logic     [NumTiles-1:0] ready_o,
  input  tile_id_t [NumTiles-1:0] sel_i,
  // Outputs, one per target tile
  output payload_t [NumTiles-1:0] data_o,
  output logic     [NumTiles-1:0] valid_o,
  input  logic     [NumTiles-1:0] ready_i
);

  localparam int unsigned IdxW = (NumTiles > 1) ? $clog2(NumTiles) : 1;

  logic     [NumTiles-1:0][NumTiles-1:0] out_req;     // [output][input]
  logic     [NumTiles-1:0][NumTiles-1:0] out_gnt;     // [output][input]
  logic     [NumTiles-1:0][IdxW-1:0]     out_gnt_idx;
  logic     [NumTiles-1:0]               out_load;
  payload_t [NumTiles-1:0]               data_q;
  logic     [NumTiles-1:0]               valid_q;

  for (genvar t = 0; t < NumTiles; t++) begin : gen_out

    for (genvar i = 0; i < NumTiles; i++) begin : gen_req
      assign out_req[t][i] = valid_i[i] && (sel_i[i] == tile_id_t'(t));
    end : gen_req

    // Register is free, or it drains in this cycle
    assign out_load[t] = !valid_q[t] || ready_i[t];

    tcdm_rr_arbiter #(
      .NumReq   (NumTiles        )
    ) i_rr_arbiter (
      .clk_i    (clk_i           ),
      .rst_n_i  (rst_n_i         ),
      .req_i    (out_req[t]      ),
      .gnt_en_i (out_load[t]     ),
      .gnt_o    (out_gnt[t]      ),
      .gnt_idx_o(out_gnt_idx[t]  )
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[t] <= 1'b0;
      end else if (out_load[t]) begin
        valid_q[t] <= |out_gnt[t];   // Empty again if nobody won
      end
    end

    always_ff @(posedge clk_i) begin
      if (|out_gnt[t]) begin
        data_q[t] <= data_i[out_gnt_idx[t]];
      end
    end

    // A stalled flit must not change or vanish
    a_hold_on_stall: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_o[t] && !ready_i[t] |=> valid_o[t] && $stable(data_o[t])
    ) else $error("crossbar output %0d changed under stall", t);

  end : gen_out

  // An input only ever requests one output, so the OR is its own grant
  always_comb begin
    ready_o = '0;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      for (int unsigned i = 0; i < NumTiles; i++) begin
        ready_o[i] = ready_o[i] | out_gnt[t][i];
      end
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule
